/* Makefile */
# Verilator build and run of the DAC front end testbench

VERILATOR ?= verilator
TOP       ?= tb_dac_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

SOURCES := $(wildcard src/*.sv testbench/*.sv testbench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
+incdir+testbench
src/dac_pkg.sv
src/spi_frame_receiver.sv
src/clear_sequencer.sv
src/frame_checker.sv
src/dac_channel_bank.sv
src/dac_top.sv
testbench/tb_dac_top.sv

/* src/clear_sequencer.sv */
`timescale 1ns/1ps

module clear_sequencer #(
   parameter int CLR_MIN_CYCLES = 40
) (
   input  logic dac_cs,
   input  logic rst_n,
   input  logic dac_clr,
   output logic clear_pulse,
   output logic inited
);

   localparam int CNT_W = $clog2(CLR_MIN_CYCLES + 1);

   // Synchronizer, delay stage and registered release edge
   logic clr_meta, clr_sync, clr_prev;
   logic clr_rise_q;
   // Low phase length, stops at the minimum
   logic [CNT_W-1:0] low_cnt;

   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         clr_meta   <= 1'b1;
         clr_sync   <= 1'b1;
         clr_prev   <= 1'b1;
         clr_rise_q <= 1'b0;
      end else begin
         clr_meta   <= dac_clr;
         clr_sync   <= clr_meta;
         clr_prev   <= clr_sync;
         clr_rise_q <= clr_sync & ~clr_prev;
      end
   end

   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         low_cnt     <= '0;
         clear_pulse <= 1'b0;
         inited      <= 1'b0;
      end else begin
         clear_pulse <= clr_rise_q;
         if (clr_rise_q) begin
            // Release, long enough low phase arms the part
            if (low_cnt == CNT_W'(CLR_MIN_CYCLES)) begin
               inited <= 1'b1;
            end
            low_cnt <= '0;
         end else if (!clr_prev && low_cnt != CNT_W'(CLR_MIN_CYCLES)) begin
            low_cnt <= low_cnt + 1'b1;
         end
      end
   end

   // Once armed, only reset disarms
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      inited |=> inited);

endmodule

/* src/dac_channel_bank.sv */
`timescale 1ns/1ps

module dac_channel_bank (
   input  logic                dac_cs,
   input  logic                rst_n,
   input  logic                clear_pulse,
   input  logic                write_valid,
   input  dac_pkg::dac_write_t write,
   output dac_pkg::dac_codes_t codes
);

   // Clear wins over a write in the same cycle
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         codes <= '0;
      end else if (clear_pulse) begin
         codes <= '0;
      end else if (write_valid) begin
         if (write.broadcast) begin
            // Address F writes all four channels
            codes.ch_a <= write.code;
            codes.ch_b <= write.code;
            codes.ch_c <= write.code;
            codes.ch_d <= write.code;
         end else begin
            case (write.channel)
               2'd0: begin
                  codes.ch_a <= write.code;
               end
               2'd1: begin
                  codes.ch_b <= write.code;
               end
               2'd2: begin
                  codes.ch_c <= write.code;
               end
               default: begin
                  codes.ch_d <= write.code;
               end
            endcase
         end
      end
   end

endmodule

/* src/dac_pkg.sv */
package dac_pkg;

   // Frame geometry
   localparam int FRAME_BITS = 32;

   // Only write-and-update is accepted
   localparam logic [3:0] CMD_WRITE_UPDATE = 4'h3;

   // Channel addresses, A..D are 0..3, F hits all four
   localparam logic [3:0] ADDR_MAX_SINGLE = 4'h3;
   localparam logic [3:0] ADDR_ALL        = 4'hF;

   // Field view of a received frame, MSB first
   typedef struct packed {
      logic [7:0]  unused;
      logic [3:0]  command;
      logic [3:0]  address;
      logic [11:0] data;
      logic [3:0]  pad;
   } dac_frame_fields_t;

   // Same 32 bits seen as shift register or as fields
   typedef union packed {
      logic [FRAME_BITS-1:0] raw;
      dac_frame_fields_t     fields;
   } dac_frame_u;

   // Four channel codes, channel A on top
   typedef struct packed {
      logic [11:0] ch_a;
      logic [11:0] ch_b;
      logic [11:0] ch_c;
      logic [11:0] ch_d;
   } dac_codes_t;

   // Verdict on the last frame
   typedef struct packed {
      logic not_inited;
      logic short_frame;
      logic long_frame;
      logic bad_command;
      logic bad_address;
   } dac_status_t;

   // Write request to the channel bank
   typedef struct packed {
      logic        broadcast;
      logic [1:0]  channel;
      logic [11:0] code;
   } dac_write_t;

endpackage

/* src/dac_top.sv */
`timescale 1ns/1ps

module dac_top #(
   parameter int CLR_MIN_CYCLES = 40
) (
   input  logic                 dac_cs,
   input  logic                 rst_n,
   input  logic                 spi_sck,
   input  logic                 spi_cs_n,
   input  logic                 spi_mosi,
   input  logic                 dac_clr,
   output logic                 dac_out,
   output dac_pkg::dac_codes_t  codes,
   output dac_pkg::dac_status_t status,
   output logic                 frame_error,
   output logic                 inited
);

   // Receiver to checker
   logic                frame_done;
   dac_pkg::dac_frame_u frame;
   logic [5:0]          bit_count;

   // Clear to receiver and bank
   logic clear_pulse;

   // Checker to bank
   logic                write_valid;
   dac_pkg::dac_write_t write;

   spi_frame_receiver u_receiver (
      .dac_cs      (dac_cs),
      .rst_n       (rst_n),
      .spi_sck     (spi_sck),
      .spi_cs_n    (spi_cs_n),
      .spi_mosi    (spi_mosi),
      .clear_pulse (clear_pulse),
      .dac_out     (dac_out),
      .frame_done  (frame_done),
      .frame       (frame),
      .bit_count   (bit_count)
   );

   clear_sequencer #(
      .CLR_MIN_CYCLES (CLR_MIN_CYCLES)
   ) u_clear (
      .dac_cs      (dac_cs),
      .rst_n       (rst_n),
      .dac_clr     (dac_clr),
      .clear_pulse (clear_pulse),
      .inited      (inited)
   );

   frame_checker u_checker (
      .dac_cs      (dac_cs),
      .rst_n       (rst_n),
      .frame_done  (frame_done),
      .frame       (frame),
      .bit_count   (bit_count),
      .inited      (inited),
      .write_valid (write_valid),
      .write       (write),
      .status      (status),
      .frame_error (frame_error)
   );

   dac_channel_bank u_bank (
      .dac_cs      (dac_cs),
      .rst_n       (rst_n),
      .clear_pulse (clear_pulse),
      .write_valid (write_valid),
      .write       (write),
      .codes       (codes)
   );

endmodule

/* src/frame_checker.sv */
`timescale 1ns/1ps

module frame_checker (
   input  logic                 dac_cs,
   input  logic                 rst_n,
   input  logic                 frame_done,
   input  dac_pkg::dac_frame_u  frame,
   input  logic [5:0]           bit_count,
   input  logic                 inited,
   output logic                 write_valid,
   output dac_pkg::dac_write_t  write,
   output dac_pkg::dac_status_t status,
   output logic                 frame_error
);

   localparam logic [5:0] FULL_COUNT = 6'(dac_pkg::FRAME_BITS);

   dac_pkg::dac_status_t next_status;
   logic                 full_frame;
   logic                 addr_ok;
   logic                 frame_ok;

   // Exact bit count gates the field checks
   assign full_frame = (bit_count == FULL_COUNT);

   // Single channel or all channels
   assign addr_ok = (frame.fields.address <= dac_pkg::ADDR_MAX_SINGLE)
                 || (frame.fields.address == dac_pkg::ADDR_ALL);

   always_comb begin
      next_status             = '0;
      next_status.not_inited  = ~inited;
      next_status.short_frame = (bit_count < FULL_COUNT);
      next_status.long_frame  = (bit_count > FULL_COUNT);
      // Fields only mean something in a full frame
      if (full_frame) begin
         next_status.bad_command = (frame.fields.command != dac_pkg::CMD_WRITE_UPDATE);
         next_status.bad_address = ~addr_ok;
      end
   end

   assign frame_ok = (next_status == '0);

   // Verdict registers hold status until the next frame end
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         status      <= '0;
         write_valid <= 1'b0;
         frame_error <= 1'b0;
      end else begin
         write_valid <= frame_done & frame_ok;
         frame_error <= frame_done & ~frame_ok;
         if (frame_done) begin
            status <= next_status;
         end
      end
   end

   // Write payload is qualified by write_valid
   always_ff @(posedge dac_cs) begin
      if (frame_done) begin
         write.broadcast <= (frame.fields.address == dac_pkg::ADDR_ALL);
         write.channel   <= frame.fields.address[1:0];
         write.code      <= frame.fields.data;
      end
   end

   // Write and error never fire together
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      !(write_valid && frame_error));

endmodule

/* src/spi_frame_receiver.sv */
`timescale 1ns/1ps

module spi_frame_receiver (
   input  logic                dac_cs,
   input  logic                rst_n,
   input  logic                spi_sck,
   input  logic                spi_cs_n,
   input  logic                spi_mosi,
   input  logic                clear_pulse,
   output logic                dac_out,
   output logic                frame_done,
   output dac_pkg::dac_frame_u frame,
   output logic [5:0]          bit_count
);

   // Two-flop synchronizers plus one delay stage for edge detect
   logic sck_meta, sck_sync, sck_prev;
   logic cs_meta, cs_sync, cs_prev;
   logic mosi_meta, mosi_sync, mosi_prev;

   // Registered edge pulses, aligned with the *_prev levels
   logic sck_rise_q, sck_fall_q;
   logic cs_rise_q, cs_fall_q;

   // Bit shown on dac_out while selected
   logic out_bit;

   // Lines idle high except data, so no edge fires out of reset
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         sck_meta  <= 1'b1;
         sck_sync  <= 1'b1;
         sck_prev  <= 1'b1;
         cs_meta   <= 1'b1;
         cs_sync   <= 1'b1;
         cs_prev   <= 1'b1;
         mosi_meta <= 1'b0;
         mosi_sync <= 1'b0;
         mosi_prev <= 1'b0;
      end else begin
         sck_meta  <= spi_sck;
         sck_sync  <= sck_meta;
         sck_prev  <= sck_sync;
         cs_meta   <= spi_cs_n;
         cs_sync   <= cs_meta;
         cs_prev   <= cs_sync;
         mosi_meta <= spi_mosi;
         mosi_sync <= mosi_meta;
         mosi_prev <= mosi_sync;
      end
   end

   // Edge pulses, one cycle each
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         sck_rise_q <= 1'b0;
         sck_fall_q <= 1'b0;
         cs_rise_q  <= 1'b0;
         cs_fall_q  <= 1'b0;
      end else begin
         sck_rise_q <= sck_sync & ~sck_prev;
         sck_fall_q <= ~sck_sync & sck_prev;
         cs_rise_q  <= cs_sync & ~cs_prev;
         cs_fall_q  <= ~cs_sync & cs_prev;
      end
   end

   // Shift register and bit counter
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         frame.raw <= '0;
         bit_count <= '0;
      end else if (clear_pulse) begin
         // Clear wipes the word like the async clear of the part
         frame.raw <= '0;
         bit_count <= '0;
      end else if (cs_fall_q) begin
         // New frame, old word stays for daisy chain replay
         bit_count <= '0;
      end else if (sck_rise_q && !cs_prev) begin
         frame.raw <= {frame.raw[dac_pkg::FRAME_BITS-2:0], mosi_prev};
         // Saturate so overlong frames stay visible
         if (bit_count != 6'd63) begin
            bit_count <= bit_count + 6'd1;
         end
      end
   end

   // Frame end pulse
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         frame_done <= 1'b0;
      end else begin
         frame_done <= cs_rise_q;
      end
   end

   // Top bit follows the word while deselected, steps on SCK fall while selected
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         out_bit <= 1'b0;
      end else if (cs_prev || sck_fall_q) begin
         out_bit <= frame.raw[dac_pkg::FRAME_BITS-1];
      end
   end

   // Serial out low when not selected
   assign dac_out = cs_prev ? 1'b0 : out_bit;

   // Count only returns to zero on a new frame or a clear
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      (bit_count != 6'd0 && !cs_fall_q && !clear_pulse) |=> (bit_count != 6'd0));

   // One pulse per chip-select rise
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      frame_done |=> !frame_done);

endmodule

/* testbench/tb_spi_tasks.svh */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Drains the testbench check pipelines, bounded
task automatic wait_checks_idle();
   int n;
   n = 0;
   do begin
      @(negedge dac_cs);
      n++;
      if (n > TIMEOUT_CYCLES) begin
         stop_with_error("checks after the last frame or clear never completed");
      end
   end while (cs_rise_pipe != '0 || clr_rise_pipe != '0);
endtask

// Polls inited after a long clear
task automatic wait_for_inited();
   int n;
   n = 0;
   while (inited !== 1'b1) begin
      @(negedge dac_cs);
      n++;
      if (n > TIMEOUT_CYCLES) begin
         stop_with_error("inited did not rise after a long clear pulse");
      end
   end
endtask

// Low pulse on dac_clr, length in dac_cs cycles
task automatic pulse_clear(input int low_cycles);
   @(negedge dac_cs);
   dac_clr = 1'b0;
   repeat (low_cycles) @(negedge dac_cs);
   dac_clr = 1'b1;
   // Any clear zeroes codes and the shift word
   exp_codes = '0;
   model_raw = '0;
   if (low_cycles >= CLR_MIN_CYCLES) begin
      exp_inited = 1'b1;
   end
   wait_checks_idle();
endtask

// One frame MSB first, nbits may be short or long of 32
task automatic send_frame(input logic [31:0] word, input int nbits);
   int   i;
   logic b;
   @(negedge dac_cs);
   spi_cs_n = 1'b0;
   for (i = 0; i < nbits; i++) begin
      // Bits past the word are zero
      b = (i < 32) ? word[31-i] : 1'b0;
      spi_mosi = b;
      repeat (SCK_PHASE) @(negedge dac_cs);
      // Still the bit from the previous fall
      exp_dout  = model_raw[31];
      dout_chk  = 1'b1;
      spi_sck   = 1'b1;
      model_raw = {model_raw[30:0], b};
      @(negedge dac_cs);
      dout_chk = 1'b0;
      repeat (SCK_PHASE - 1) @(negedge dac_cs);
      spi_sck = 1'b0;
   end
   repeat (SCK_PHASE) @(negedge dac_cs);
   // Last fall has settled, check it on the way out
   exp_dout = model_raw[31];
   dout_chk = 1'b1;
   spi_cs_n = 1'b1;
   apply_frame(word, nbits);
   @(negedge dac_cs);
   dout_chk = 1'b0;
   wait_checks_idle();
endtask

`endif

/* testbench/tb_dac_top.sv */
`timescale 1ns/1ps

module tb_dac_top;

   localparam int CLR_MIN_CYCLES = 40;
   localparam int SCK_PHASE      = 4;
   localparam int TIMEOUT_CYCLES = 100;
   localparam int CLR_LONG       = 44;
   localparam int CLR_SHORT      = 10;

   logic dac_cs;
   logic rst_n;
   logic spi_sck;
   logic spi_cs_n;
   logic spi_mosi;
   logic dac_clr;
   logic dac_out;
   logic frame_error;
   logic inited;
   dac_pkg::dac_codes_t  codes;
   dac_pkg::dac_status_t status;

   // Reference model state
   dac_pkg::dac_codes_t  exp_codes;
   dac_pkg::dac_status_t exp_status;
   logic                 exp_error;
   logic                 exp_inited;
   logic [31:0]          model_raw;
   logic                 exp_dout;
   logic                 dout_chk;
   integer               seed;
   int                   fail_count;
   int                   i;

   // Own view of the chip-select and clear edges
   logic       cs_q;
   logic       clr_q;
   logic [5:0] cs_rise_pipe;
   logic [4:0] clr_rise_pipe;
   logic [2:0] cs_hist;

   dac_top #(
      .CLR_MIN_CYCLES (CLR_MIN_CYCLES)
   ) DUT (
      .dac_cs      (dac_cs),
      .rst_n       (rst_n),
      .spi_sck     (spi_sck),
      .spi_cs_n    (spi_cs_n),
      .spi_mosi    (spi_mosi),
      .dac_clr     (dac_clr),
      .dac_out     (dac_out),
      .codes       (codes),
      .status      (status),
      .frame_error (frame_error),
      .inited      (inited)
   );

   task automatic stop_with_error(input string what);
      fail_count++;
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
      fail_count++;
      $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "stopping at first mismatch");
   endtask

   // Random word, command and address forced
   function automatic logic [31:0] make_word(input logic [3:0] cmd, input logic [3:0] addr);
      logic [31:0] w;
      w = $random(seed);
      w[23:20] = cmd;
      w[19:16] = addr;
      return w;
   endfunction

   // Verdict and channel update for a finished frame
   function automatic void apply_frame(input logic [31:0] word, input int nbits);
      logic [3:0]  cmd;
      logic [3:0]  addr;
      logic [11:0] data;
      cmd  = word[23:20];
      addr = word[19:16];
      data = word[15:4];
      exp_status             = '0;
      exp_status.not_inited  = ~exp_inited;
      exp_status.short_frame = (nbits < 32);
      exp_status.long_frame  = (nbits > 32);
      // Field checks only on a full frame
      if (nbits == 32) begin
         exp_status.bad_command = (cmd != 4'h3);
         exp_status.bad_address = !((addr <= 4'h3) || (addr == 4'hF));
      end
      exp_error = (exp_status != '0);
      if (!exp_error) begin
         if (addr == 4'hF) begin
            exp_codes = {data, data, data, data};
         end else begin
            case (addr[1:0])
               2'd0: exp_codes.ch_a = data;
               2'd1: exp_codes.ch_b = data;
               2'd2: exp_codes.ch_c = data;
               default: exp_codes.ch_d = data;
            endcase
         end
      end
   endfunction

   `include "tb_spi_tasks.svh"

   initial begin
      dac_cs = 1'b0;
      forever #50 dac_cs = ~dac_cs;
   end

   // Bit k of a pipe is seen k+1 edges after the sampled rise
   always_ff @(posedge dac_cs or negedge rst_n) begin
      if (!rst_n) begin
         cs_q          <= 1'b1;
         clr_q         <= 1'b1;
         cs_rise_pipe  <= '0;
         clr_rise_pipe <= '0;
         cs_hist       <= '1;
      end else begin
         cs_q          <= spi_cs_n;
         clr_q         <= dac_clr;
         cs_rise_pipe  <= {cs_rise_pipe[4:0], spi_cs_n & ~cs_q};
         clr_rise_pipe <= {clr_rise_pipe[3:0], dac_clr & ~clr_q};
         cs_hist       <= {cs_hist[1:0], spi_cs_n};
      end
   end

   // Verdict, 5 edges after cs sampled high
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      cs_rise_pipe[4] |-> (status == exp_status))
      else report_mismatch("status", {59'd0, exp_status}, {59'd0, $sampled(status)});

   assert property (@(posedge dac_cs) disable iff (!rst_n)
      cs_rise_pipe[4] |-> (frame_error == exp_error))
      else report_mismatch("frame_error", {63'd0, exp_error}, {63'd0, $sampled(frame_error)});

   // Codes one edge later
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      cs_rise_pipe[5] |-> (codes == exp_codes))
      else report_mismatch("codes", {16'd0, exp_codes}, {16'd0, $sampled(codes)});

   // Clear results
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      clr_rise_pipe[3] |-> (inited == exp_inited))
      else report_mismatch("inited", {63'd0, exp_inited}, {63'd0, $sampled(inited)});

   assert property (@(posedge dac_cs) disable iff (!rst_n)
      clr_rise_pipe[4] |-> (codes == exp_codes))
      else report_mismatch("codes", {16'd0, exp_codes}, {16'd0, $sampled(codes)});

   // Daisy-chain bit, and quiet line while deselected
   assert property (@(posedge dac_cs) disable iff (!rst_n)
      dout_chk |-> (dac_out == exp_dout))
      else report_mismatch("dac_out", {63'd0, exp_dout}, {63'd0, $sampled(dac_out)});

   assert property (@(posedge dac_cs) disable iff (!rst_n)
      cs_hist[2] |-> (dac_out == 1'b0))
      else report_mismatch("dac_out", 64'd0, {63'd0, $sampled(dac_out)});

   initial begin
      seed       = 32'h84c6;
      fail_count = 0;
      rst_n      = 1'b0;
      spi_sck    = 1'b0;
      spi_cs_n   = 1'b1;
      spi_mosi   = 1'b0;
      dac_clr    = 1'b1;
      dout_chk   = 1'b0;
      exp_dout   = 1'b0;
      exp_codes  = '0;
      exp_status = '0;
      exp_error  = 1'b0;
      exp_inited = 1'b0;
      model_raw  = '0;
      repeat (16) @(negedge dac_cs);
      rst_n = 1'b1;
      repeat (4) @(negedge dac_cs);

      // Refused before any clear, and after a short one
      send_frame(make_word(4'h3, 4'h0), 32);
      pulse_clear(CLR_SHORT);
      send_frame(make_word(4'h3, 4'h2), 32);

      // Long clear arms the part, then one write per channel
      pulse_clear(CLR_LONG);
      wait_for_inited();
      for (i = 0; i < 4; i++) begin
         send_frame(make_word(4'h3, i[3:0]), 32);
      end

      // Broadcast, then a single write on top
      send_frame(make_word(4'h3, 4'hF), 32);
      send_frame(make_word(4'h3, 4'h1), 32);

      // Wrong bit counts
      send_frame(make_word(4'h3, 4'h0), 31);
      send_frame(make_word(4'h3, 4'h2), 33);

      // Illegal command, then illegal address
      for (i = 0; i < 3; i++) begin
         logic [31:0] r;
         r = $random(seed);
         send_frame(make_word((r[3:0] == 4'h3) ? 4'h7 : r[3:0], 4'h1), 32);
         r = $random(seed);
         send_frame(make_word(4'h3, 4'h4 + (r[3:0] % 4'd11)), 32);
      end

      // Legal word again so the next frame replays it
      send_frame(make_word(4'h3, 4'h3), 32);
      send_frame(make_word(4'h3, 4'hF), 32);
      pulse_clear(CLR_LONG);
      send_frame(make_word(4'h3, 4'h2), 32);

      if (fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
